//--- src/icache_pkg.sv
`default_nettype none

package icache_pkg;

    //////////////////////////////
    // cache geometry
    //////////////////////////////

    localparam int WAYS           = 4;
    localparam int SETS           = 32;
    localparam int WORDS_PER_LINE = 16;
    localparam int TAG_W          = 21;
    localparam int INDEX_W        = 5;
    localparam int OFFSET_W       = 6;
    localparam int LINE_W         = 512;
    localparam int WORD_W         = 32;

    typedef logic [1:0] way_t;

    //////////////////////////////
    // address views
    //////////////////////////////

    // lookup fields, msb first
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-3:0] wsel;
        logic [1:0]          bsel;
    } addr_fields_t;

    // flat word for memory and response, fields for lookup
    typedef union packed {
        logic [31:0]  word;
        addr_fields_t f;
    } addr_u;

    //////////////////////////////
    // pipeline records
    //////////////////////////////

    // stage two register
    typedef struct packed {
        logic  valid;
        addr_u addr;
        logic  hit;
        way_t  hit_way;
        logic  bypass;
    } lookup_t;

    // response to the fetch unit
    typedef struct packed {
        logic              ok1;
        logic              ok2;
        logic [31:0]       addr;
        logic [WORD_W-1:0] inst1;
        logic [WORD_W-1:0] inst2;
    } fetch_rsp_t;

endpackage

`default_nettype wire

//--- src/icache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array import icache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  addr_u lookup_addr_i,
    input  logic  fill_en_i,
    input  way_t  fill_way_i,
    input  addr_u fill_addr_i,
    output logic  hit_o,
    output way_t  hit_way_o,
    output logic  bypass_o
);

    logic [TAG_W-1:0] tag_q   [WAYS][SETS];
    logic             valid_q [WAYS][SETS];
    logic             same_set;
    logic             fill_tag_match;
    logic [WAYS-1:0]  way_match;

    //////////////////////////////
    // lookup
    //////////////////////////////

    // refill of this cycle lands in the set being looked up
    assign same_set = fill_en_i && (fill_addr_i.f.index == lookup_addr_i.f.index);
    assign fill_tag_match = (fill_addr_i.f.tag == lookup_addr_i.f.tag);

    // fill way holds stale contents until the edge, so use the incoming tag
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            if (same_set && (fill_way_i == way_t'(w))) begin
                way_match[w] = fill_tag_match;
            end else begin
                way_match[w] = valid_q[w][lookup_addr_i.f.index] &&
                               (tag_q[w][lookup_addr_i.f.index] == lookup_addr_i.f.tag);
            end
        end
    end

    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (way_match[w]) begin
                hit_way_o = way_t'(w);
            end
        end
    end

    assign hit_o    = |way_match;
    assign bypass_o = same_set && fill_tag_match;

    //////////////////////////////
    // refill write
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int w = 0; w < WAYS; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    valid_q[w][s] <= 1'b0;
                end
            end
        end else if (fill_en_i) begin
            valid_q[fill_way_i][fill_addr_i.f.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            tag_q[fill_way_i][fill_addr_i.f.index] <= fill_addr_i.f.tag;
        end
    end

endmodule

`default_nettype wire

//--- src/icache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data_array import icache_pkg::*; (
    input  logic                clk,
    input  logic [INDEX_W-1:0]  read_index_i,
    input  logic [OFFSET_W-3:0] word_sel_i,
    input  way_t                way_i,
    input  logic                bypass_i,
    input  logic                fill_en_i,
    input  way_t                fill_way_i,
    input  logic [INDEX_W-1:0]  fill_index_i,
    input  logic [LINE_W-1:0]   fill_line_i,
    output logic [WORD_W-1:0]   inst1_o,
    output logic [WORD_W-1:0]   inst2_o
);

    logic [WORD_W-1:0]   rd_word   [WAYS][WORDS_PER_LINE];
    logic [WORD_W-1:0]   fill_word [WORDS_PER_LINE];
    logic [WORD_W-1:0]   byp_word  [WORDS_PER_LINE];
    logic [LINE_W-1:0]   fill_line_q;
    logic [OFFSET_W-3:0] word_next;

    // split refill line, word 0 in the low bits
    for (genvar b = 0; b < WORDS_PER_LINE; b++) begin : g_split
        assign fill_word[b] = fill_line_i[b*WORD_W +: WORD_W];
        assign byp_word[b]  = fill_line_q[b*WORD_W +: WORD_W];
    end

    //////////////////////////////
    // word banks
    //////////////////////////////

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        for (genvar b = 0; b < WORDS_PER_LINE; b++) begin : g_bank
            logic [WORD_W-1:0] mem [SETS];
            logic [WORD_W-1:0] rd_q;

            always_ff @(posedge clk) begin
                if (fill_en_i && (fill_way_i == way_t'(w))) begin
                    mem[fill_index_i] <= fill_word[b];
                end
                rd_q <= mem[read_index_i];
            end

            assign rd_word[w][b] = rd_q;
        end
    end

    //////////////////////////////
    // bypass and word select
    //////////////////////////////

    // a read in the refill cycle sees the old bank contents,
    // so keep the refilled line for the following cycle
    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            fill_line_q <= fill_line_i;
        end
    end

    // wraps at the line end, the top drops that word
    assign word_next = word_sel_i + 1'b1;

    always_comb begin
        if (bypass_i) begin
            inst1_o = byp_word[word_sel_i];
            inst2_o = byp_word[word_next];
        end else begin
            inst1_o = rd_word[way_i][word_sel_i];
            inst2_o = rd_word[way_i][word_next];
        end
    end

endmodule

`default_nettype wire

//--- src/icache_plru.sv
`timescale 1ns/1ps
`default_nettype none

module icache_plru import icache_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               touch_i,
    input  logic [INDEX_W-1:0] index_i,
    input  way_t               way_i,
    output way_t               victim_o
);

    // bit 2 root, bit 1 leaf of ways 2/3, bit 0 leaf of ways 0/1
    logic [2:0] tree_q [SETS];
    logic [2:0] cur;

    assign cur = tree_q[index_i];

    //////////////////////////////
    // victim walk
    //////////////////////////////

    // root picks the half, that half's leaf picks the way
    always_comb begin
        victim_o[1] = cur[2];
        victim_o[0] = cur[2] ? cur[1] : cur[0];
    end

    //////////////////////////////
    // update on use
    //////////////////////////////

    // point away from the way just used
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                tree_q[s] <= 3'b000;
            end
        end else if (touch_i) begin
            tree_q[index_i][2] <= ~way_i[1];
            if (way_i[1]) begin
                tree_q[index_i][1] <= ~way_i[0];
            end else begin
                tree_q[index_i][0] <= ~way_i[0];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/icache_miss_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_miss_ctrl import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        miss_i,
    input  addr_u       line_addr_i,
    input  logic        ret_valid_i,
    output logic        rd_req_o,
    output logic [31:0] rd_addr_o,
    output logic        fill_en_o,
    output logic        stall_o
);

    logic        busy_q;
    addr_u       line;

    // line aligned view of the missing address
    always_comb begin
        line        = line_addr_i;
        line.f.wsel = '0;
        line.f.bsel = '0;
    end

    //////////////////////////////
    // request and stall
    //////////////////////////////

    // request goes out in the miss cycle itself,
    // then stays up until the line comes back
    assign rd_req_o  = miss_i || busy_q;

    // stage two holds the missing address until the return
    assign rd_addr_o = line.word;

    // return cycle writes the arrays and releases the pipe
    assign fill_en_o = rd_req_o && ret_valid_i;
    assign stall_o   = rd_req_o && !ret_valid_i;

    //////////////////////////////
    // outstanding request
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= rd_req_o && !ret_valid_i;
        end
    end

endmodule

`default_nettype wire

//--- src/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid_i,
    input  addr_u             paddr_i,
    output logic              stall_o,
    output fetch_rsp_t        rsp_o,
    output logic              rd_req_o,
    output logic [31:0]       rd_addr_o,
    input  logic              ret_valid_i,
    input  logic [LINE_W-1:0] ret_data_i
);

    lookup_t             s2_q;
    logic                lk_hit;
    way_t                lk_hit_way;
    logic                lk_bypass;
    logic                fill_en;
    way_t                victim;
    logic                miss;
    logic [INDEX_W-1:0]  read_index;
    logic [WORD_W-1:0]   arr_inst1;
    logic [WORD_W-1:0]   arr_inst2;
    logic [WORD_W-1:0]   ret_word [WORDS_PER_LINE];
    logic [OFFSET_W-3:0] s2_wsel;
    logic [OFFSET_W-3:0] s2_wnext;
    logic                rsp_ok1;
    way_t                touch_way;

    //////////////////////////////
    // stage one
    //////////////////////////////

    // while stalled the banks keep reading the waiting set
    assign read_index = stall_o ? s2_q.addr.f.index : paddr_i.f.index;

    icache_tag_array i_tag (
        .clk           (clk),
        .rst           (rst),
        .lookup_addr_i (paddr_i),
        .fill_en_i     (fill_en),
        .fill_way_i    (victim),
        .fill_addr_i   (s2_q.addr),
        .hit_o         (lk_hit),
        .hit_way_o     (lk_hit_way),
        .bypass_o      (lk_bypass)
    );

    icache_data_array i_data (
        .clk          (clk),
        .read_index_i (read_index),
        .word_sel_i   (s2_wsel),
        .way_i        (s2_q.hit_way),
        .bypass_i     (s2_q.bypass),
        .fill_en_i    (fill_en),
        .fill_way_i   (victim),
        .fill_index_i (s2_q.addr.f.index),
        .fill_line_i  (ret_data_i),
        .inst1_o      (arr_inst1),
        .inst2_o      (arr_inst2)
    );

    // stage two register, frozen on a miss
    always_ff @(posedge clk) begin
        if (!rst) begin
            s2_q <= '0;
        end else if (!stall_o) begin
            s2_q.valid   <= req_valid_i;
            s2_q.addr    <= paddr_i;
            s2_q.hit     <= lk_hit;
            s2_q.hit_way <= lk_hit_way;
            s2_q.bypass  <= lk_bypass;
        end
    end

    //////////////////////////////
    // stage two
    //////////////////////////////

    assign miss = s2_q.valid && !s2_q.hit;

    icache_miss_ctrl i_miss (
        .clk         (clk),
        .rst         (rst),
        .miss_i      (miss),
        .line_addr_i (s2_q.addr),
        .ret_valid_i (ret_valid_i),
        .rd_req_o    (rd_req_o),
        .rd_addr_o   (rd_addr_o),
        .fill_en_o   (fill_en),
        .stall_o     (stall_o)
    );

    // hits touch their own way, refills the victim
    assign touch_way = s2_q.hit ? s2_q.hit_way : victim;

    icache_plru i_plru (
        .clk      (clk),
        .rst      (rst),
        .touch_i  (rsp_ok1),
        .index_i  (s2_q.addr.f.index),
        .way_i    (touch_way),
        .victim_o (victim)
    );

    // returned line, forwarded on a miss
    always_comb begin
        for (int b = 0; b < WORDS_PER_LINE; b++) begin
            ret_word[b] = ret_data_i[b*WORD_W +: WORD_W];
        end
    end

    assign s2_wsel  = s2_q.addr.f.wsel;
    assign s2_wnext = s2_wsel + 1'b1;
    assign rsp_ok1  = s2_q.valid && (s2_q.hit || fill_en);

    // second word only inside the same line
    always_comb begin
        rsp_o.ok1  = rsp_ok1;
        rsp_o.ok2  = rsp_ok1 && (s2_wsel != '1);
        rsp_o.addr = s2_q.addr.word;
        if (s2_q.hit) begin
            rsp_o.inst1 = arr_inst1;
            rsp_o.inst2 = arr_inst2;
        end else begin
            rsp_o.inst1 = ret_word[s2_wsel];
            rsp_o.inst2 = ret_word[s2_wnext];
        end
    end

endmodule

`default_nettype wire

//--- tests/icache_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module icache_asserts import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  fetch_rsp_t  rsp_i,
    input  logic        stall_i,
    input  logic        rd_req_i,
    input  logic [31:0] rd_addr_i,
    input  logic        ret_valid_i
);

    // memory word = byte address ^ this pattern
    localparam logic [31:0] MEM_PATTERN = 32'h3c5a_e187;

    int unsigned fail_count = 0;
    logic [31:0] word1_addr;
    logic [31:0] word2_addr;

    assign word1_addr = {rsp_i.addr[31:2], 2'b00};
    assign word2_addr = word1_addr + 32'd4;

    //////////////////////////////
    // response contents
    //////////////////////////////

    a_inst1: assert property (@(posedge clk) disable iff (!rst)
        rsp_i.ok1 |-> (rsp_i.inst1 == (word1_addr ^ MEM_PATTERN)))
        else begin
            fail_count++;
            $error("inst1 wrong for address %h", rsp_i.addr);
        end

    a_inst2: assert property (@(posedge clk) disable iff (!rst)
        (rsp_i.ok1 && rsp_i.ok2) |-> (rsp_i.inst2 == (word2_addr ^ MEM_PATTERN)))
        else begin
            fail_count++;
            $error("inst2 wrong for address %h", rsp_i.addr);
        end

    // second word only inside the line
    a_ok2: assert property (@(posedge clk) disable iff (!rst)
        rsp_i.ok2 == (rsp_i.ok1 && (rsp_i.addr[5:2] != 4'hf)))
        else begin
            fail_count++;
            $error("ok2 wrong for address %h", rsp_i.addr);
        end

    //////////////////////////////
    // memory handshake
    //////////////////////////////

    a_rd_aligned: assert property (@(posedge clk) disable iff (!rst)
        rd_req_i |-> (rd_addr_i[5:0] == 6'd0))
        else begin
            fail_count++;
            $error("read address %h not line aligned", rd_addr_i);
        end

    a_rd_held: assert property (@(posedge clk) disable iff (!rst)
        (rd_req_i && !ret_valid_i) |=> (rd_req_i && $stable(rd_addr_i)))
        else begin
            fail_count++;
            $error("read request dropped or changed before return");
        end

    // return cycle delivers the missed fetch and releases the pipe
    a_ret_rsp: assert property (@(posedge clk) disable iff (!rst)
        ret_valid_i |-> (rsp_i.ok1 && !stall_i))
        else begin
            fail_count++;
            $error("no response or still stalled in the return cycle");
        end

    // nothing delivered while waiting on memory
    a_stall_quiet: assert property (@(posedge clk) disable iff (!rst)
        stall_i |-> !rsp_i.ok1)
        else begin
            fail_count++;
            $error("response delivered during a stall");
        end

endmodule

`default_nettype wire

//--- tests/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb import icache_pkg::*; ();

    // same fill rule as the bound checker
    localparam logic [31:0] MEM_PATTERN = 32'h3c5a_e187;
    localparam int          WAIT_LIMIT  = 64;
    localparam time         CLK_PERIOD  = 8;

    logic              clk;
    logic              rst;
    logic              req_valid_i;
    addr_u             paddr_i;
    logic              stall_o;
    fetch_rsp_t        rsp_o;
    logic              rd_req_o;
    logic [31:0]       rd_addr_o;
    logic              ret_valid_i;
    logic [LINE_W-1:0] ret_data_i;

    // falling edge samples, used by the rising edge processes
    logic        smp_stall;
    logic        smp_rd_req;
    logic [31:0] smp_rd_addr;

    logic [31:0] sent_q [$];
    time         sent_t [$];
    logic [15:0] lfsr_q;
    logic        mem_busy;
    int          mem_wait;
    int          mem_dly;
    logic [31:0] mem_line;

    // reference cache state
    logic             mdl_valid [SETS][WAYS];
    logic [TAG_W-1:0] mdl_tag   [SETS][WAYS];
    logic             mdl_root  [SETS];
    logic             mdl_leaf  [SETS][2];

    icache_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .paddr_i     (paddr_i),
        .stall_o     (stall_o),
        .rsp_o       (rsp_o),
        .rd_req_o    (rd_req_o),
        .rd_addr_o   (rd_addr_o),
        .ret_valid_i (ret_valid_i),
        .ret_data_i  (ret_data_i)
    );

    bind icache_top icache_asserts i_asserts (
        .clk         (clk),
        .rst         (rst),
        .rsp_i       (rsp_o),
        .stall_i     (stall_o),
        .rd_req_i    (rd_req_o),
        .rd_addr_i   (rd_addr_o),
        .ret_valid_i (ret_valid_i)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("ERROR at %0t ns: %s", $time, msg));
    endtask

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [LINE_W-1:0] line_data(input logic [31:0] base);
        logic [LINE_W-1:0] l;
        for (int b = 0; b < WORDS_PER_LINE; b++) begin
            l[b*WORD_W +: WORD_W] = (base + 32'(b * 4)) ^ MEM_PATTERN;
        end
        return l;
    endfunction

    function automatic logic [31:0] set_addr(input int tag, input int set, input int word);
        return (32'(tag) << 11) | (32'(set) << 6) | (32'(word) << 2);
    endfunction

    // root 0 means ways 0-1, a leaf of 0 means the lower way
    function automatic int pick_victim(input int s);
        int half;
        half = mdl_root[s] ? 1 : 0;
        return half * 2 + (mdl_leaf[s][half] ? 1 : 0);
    endfunction

    function automatic void note_use(input int s, input int w);
        mdl_root[s]        = (w < 2);
        mdl_leaf[s][w / 2] = (w % 2 == 0);
    endfunction

    // returns the expected hit and updates the reference state
    function automatic bit model_access(input logic [31:0] a);
        addr_u u;
        int    s;
        int    w;
        bit    hit;
        u   = a;
        s   = int'(u.f.index);
        w   = 0;
        hit = 1'b0;
        for (int i = 0; i < WAYS; i++) begin
            if (mdl_valid[s][i] && (mdl_tag[s][i] == u.f.tag)) begin
                hit = 1'b1;
                w   = i;
            end
        end
        if (!hit) begin
            w              = pick_victim(s);
            mdl_valid[s][w] = 1'b1;
            mdl_tag[s][w]   = u.f.tag;
        end
        note_use(s, w);
        return hit;
    endfunction

    //////////////////////////////
    // memory model
    //////////////////////////////

    always @(posedge clk) begin
        if (!rst) begin
            ret_valid_i <= 1'b0;
            mem_busy    <= 1'b0;
        end else if (ret_valid_i) begin
            ret_valid_i <= 1'b0;
            mem_busy    <= 1'b0;
        end else if (mem_busy) begin
            if (mem_wait == 1) begin
                ret_valid_i <= 1'b1;
                ret_data_i  <= line_data(mem_line);
            end else begin
                mem_wait <= mem_wait - 1;
            end
        end else if (smp_rd_req) begin
            assert (sent_q.size() != 0 && smp_rd_addr == {sent_q[0][31:6], 6'd0})
                else value_error($sformatf("read address %h is not the pending line", smp_rd_addr));
            // three bits give 1 to 6 cycles
            mem_dly = 0;
            for (int i = 0; i < 3; i++) begin
                lfsr_q  = lfsr_next(lfsr_q);
                mem_dly = (mem_dly << 1) | int'(lfsr_q[0]);
            end
            mem_busy <= 1'b1;
            mem_line <= smp_rd_addr;
            mem_wait <= 1 + mem_dly % 6;
        end
    end

    //////////////////////////////
    // response monitor
    //////////////////////////////

    always @(negedge clk) begin : monitor
        logic [31:0] exp_addr;
        time         t_acc;
        bit          exp_hit;
        smp_stall   = stall_o;
        smp_rd_req  = rd_req_o;
        smp_rd_addr = rd_addr_o;
        if (i_dut.i_asserts.fail_count != 0) begin
            abort_run("A bound assertion on the DUT ports failed");
        end
        if (rst && rsp_o.ok1) begin
            assert (sent_q.size() != 0) else abort_run("Response arrived with no request pending");
            exp_addr = sent_q.pop_front();
            t_acc    = sent_t.pop_front();
            exp_hit  = model_access(exp_addr);
            assert (rsp_o.addr == exp_addr)
                else value_error($sformatf("response address %h, expected %h", rsp_o.addr, exp_addr));
            assert (exp_hit == (($time - t_acc) < CLK_PERIOD))
                else value_error($sformatf("address %h expected hit=%0d", exp_addr, exp_hit));
            assert (!exp_hit || !rd_req_o)
                else value_error($sformatf("memory read on a hit to %h", exp_addr));
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // puts a request on the inputs and holds it until accepted
    task automatic present(input logic [31:0] a, input bit at_once);
        int n;
        bit taken;
        req_valid_i <= 1'b1;
        paddr_i     <= a;
        n           = 0;
        taken       = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = !smp_stall;
            n++;
            assert (taken || !at_once)
                else value_error($sformatf("stall while issuing hit %h", a));
            if (n > WAIT_LIMIT) begin
                abort_run("Timeout waiting for a request to be accepted");
            end
        end
        sent_q.push_back(a);
        sent_t.push_back($time);
    endtask

    task automatic drain();
        int n;
        req_valid_i <= 1'b0;
        n = 0;
        while (sent_q.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("Timeout waiting for outstanding responses");
            end
        end
    endtask

    task automatic fetch(input logic [31:0] a);
        present(a, 1'b0);
        drain();
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b0;
        req_valid_i = 1'b0;
        paddr_i     = '0;
        ret_valid_i = 1'b0;
        ret_data_i  = '0;
        lfsr_q      = 16'd3;
        for (int s = 0; s < SETS; s++) begin
            mdl_root[s]    = 1'b0;
            mdl_leaf[s][0] = 1'b0;
            mdl_leaf[s][1] = 1'b0;
            for (int w = 0; w < WAYS; w++) begin
                mdl_valid[s][w] = 1'b0;
            end
        end
        repeat (10) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        assert (!stall_o && !rd_req_o && !rsp_o.ok1 && !rsp_o.ok2)
            else value_error("outputs not idle after reset");
        @(posedge clk);

        // miss, hits in the same line, last word of a line
        fetch(32'h0000_1000);
        fetch(32'h0000_1004);
        fetch(32'h0000_103c);

        // next request waits through the refill and hits by bypass
        present(32'h0000_4080, 1'b0);
        present(32'h0000_4088, 1'b0);
        drain();

        // replacement in set 5: A B C D, hit A, E, then A C D and B
        for (int t = 1; t <= 4; t++) begin
            fetch(set_addr(t, 5, t));
        end
        fetch(set_addr(1, 5, 0));
        fetch(set_addr(5, 5, 3));
        fetch(set_addr(1, 5, 9));
        fetch(set_addr(3, 5, 15));
        fetch(set_addr(4, 5, 2));
        fetch(set_addr(2, 5, 7));

        // warm eight sets, then one hit per cycle
        for (int s = 8; s < 16; s++) begin
            fetch(set_addr(7, s, 0));
        end
        for (int s = 8; s < 16; s++) begin
            present(set_addr(7, s, s), 1'b1);
        end
        drain();

        repeat (4) @(posedge clk);
        if (i_dut.i_asserts.fail_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abort_run("A bound assertion on the DUT ports failed");
        end
    end

endmodule

`default_nettype wire

//--- icache.f
src/icache_pkg.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_plru.sv
src/icache_miss_ctrl.sv
src/icache_top.sv
tests/icache_asserts.sv
tests/icache_tb.sv
